/* rtl/karatsuba_pkg.sv */
package karatsuba_pkg;

  // Operand width used when the top level is not overridden
  localparam int DEFAULT_OPERAND_W = 10;

  // What the half multiplier takes from the two operands
  typedef enum logic [1:0] {
    MULT_LOW  = 2'b00,
    MULT_HIGH = 2'b01,
    MULT_SUM  = 2'b10
  } mult_sel_t;

  // Left shift applied to the partial product before it meets the accumulator
  typedef enum logic [1:0] {
    SHIFT_NONE = 2'b00,
    SHIFT_HALF = 2'b01,
    SHIFT_FULL = 2'b10
  } shift_sel_t;

endpackage

/* rtl/karatsuba_operand_capture.sv */
`timescale 1ns/1ns

module karatsuba_operand_capture #(
  parameter int OPERAND_W = karatsuba_pkg::DEFAULT_OPERAND_W
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic [OPERAND_W-1:0] a,
  input  logic [OPERAND_W-1:0] b,
  output logic [OPERAND_W-1:0] op_a,
  output logic [OPERAND_W-1:0] op_b,
  output logic                 go
);

  // Operands are held between starts
  always_ff @(posedge clk) begin
    if (reset) begin
      op_a <= '0;
      op_b <= '0;
    end else if (start) begin
      op_a <= a;
      op_b <= b;
    end
  end

  // go lines up with the freshly captured operands
  always_ff @(posedge clk) begin
    if (reset) begin
      go <= 1'b0;
    end else begin
      go <= start;
    end
  end

endmodule

/* rtl/karatsuba_cu.sv */
`timescale 1ns/1ns

module karatsuba_cu (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     go,
  output logic                     load_op,
  output logic                     load_acc,
  output logic                     acc_from_alu,
  output logic                     load_tmp,
  output logic                     alu_sub,
  output logic                     done,
  output karatsuba_pkg::mult_sel_t mult_sel,
  output karatsuba_pkg::shift_sel_t shift_sel
);

  import karatsuba_pkg::*;

  typedef enum logic [2:0] {
    IDLE = 3'd0,
    S0   = 3'd1,
    S1   = 3'd2,
    S2   = 3'd3,
    S3   = 3'd4,
    S4   = 3'd5,
    S5   = 3'd6,
    S6   = 3'd7
  } state_t;

  state_t state;
  state_t state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // A go seen outside IDLE is dropped
  always_comb begin
    case (state)
      IDLE:    state_next = go ? S0 : IDLE;
      S0:      state_next = S1;
      S1:      state_next = S2;
      S2:      state_next = S3;
      S3:      state_next = S4;
      S4:      state_next = S5;
      S5:      state_next = S6;
      S6:      state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_comb begin
    load_op      = 1'b0;
    load_acc     = 1'b0;
    acc_from_alu = 1'b0;
    load_tmp     = 1'b0;
    alu_sub      = 1'b0;
    done         = 1'b0;
    mult_sel     = MULT_LOW;
    shift_sel    = SHIFT_NONE;
    case (state)
      IDLE: begin
        load_op = 1'b1;
      end
      // acc = z0
      S0: begin
        mult_sel = MULT_LOW;
        load_acc = 1'b1;
      end
      // tmp = z2
      S1: begin
        mult_sel = MULT_HIGH;
        load_tmp = 1'b1;
      end
      S2: begin
        load_acc     = 1'b1;
        acc_from_alu = 1'b1;
        shift_sel    = SHIFT_FULL;
      end
      // Subtract z2 from the middle term while z0 is fetched again
      S3: begin
        load_acc     = 1'b1;
        acc_from_alu = 1'b1;
        alu_sub      = 1'b1;
        shift_sel    = SHIFT_HALF;
        mult_sel     = MULT_LOW;
        load_tmp     = 1'b1;
      end
      S4: begin
        load_acc     = 1'b1;
        acc_from_alu = 1'b1;
        alu_sub      = 1'b1;
        shift_sel    = SHIFT_HALF;
        mult_sel     = MULT_SUM;
        load_tmp     = 1'b1;
      end
      S5: begin
        load_acc     = 1'b1;
        acc_from_alu = 1'b1;
        shift_sel    = SHIFT_HALF;
      end
      S6: begin
        done = 1'b1;
      end
      default: begin
        done = 1'b0;
      end
    endcase
  end

endmodule

/* rtl/karatsuba_half_mult.sv */
`timescale 1ns/1ns

module karatsuba_half_mult #(
  parameter int OPERAND_W = karatsuba_pkg::DEFAULT_OPERAND_W,
  localparam int HALF_W = OPERAND_W / 2,
  localparam int MULT_W = 2 * HALF_W + 2
) (
  input  logic [OPERAND_W-1:0]     op_a,
  input  logic [OPERAND_W-1:0]     op_b,
  input  karatsuba_pkg::mult_sel_t mult_sel,
  output logic [MULT_W-1:0]        mult_out
);

  import karatsuba_pkg::*;

  logic [HALF_W-1:0] a_lo;
  logic [HALF_W-1:0] a_hi;
  logic [HALF_W-1:0] b_lo;
  logic [HALF_W-1:0] b_hi;
  logic [HALF_W:0]   a_sum;
  logic [HALF_W:0]   b_sum;
  logic [HALF_W:0]   mul_a;
  logic [HALF_W:0]   mul_b;

  assign a_lo = op_a[HALF_W-1:0];
  assign a_hi = op_a[OPERAND_W-1:HALF_W];
  assign b_lo = op_b[HALF_W-1:0];
  assign b_hi = op_b[OPERAND_W-1:HALF_W];

  // Half-sums keep their carry, so the factors are one bit wider
  assign a_sum = {1'b0, a_lo} + {1'b0, a_hi};
  assign b_sum = {1'b0, b_lo} + {1'b0, b_hi};

  always_comb begin
    case (mult_sel)
      MULT_HIGH: begin
        mul_a = {1'b0, a_hi};
        mul_b = {1'b0, b_hi};
      end
      MULT_SUM: begin
        mul_a = a_sum;
        mul_b = b_sum;
      end
      default: begin
        mul_a = {1'b0, a_lo};
        mul_b = {1'b0, b_lo};
      end
    endcase
  end

  assign mult_out = MULT_W'(mul_a) * MULT_W'(mul_b);

endmodule

/* rtl/karatsuba_alu.sv */
`timescale 1ns/1ns

module karatsuba_alu #(
  parameter int OPERAND_W = karatsuba_pkg::DEFAULT_OPERAND_W,
  localparam int HALF_W = OPERAND_W / 2,
  localparam int PROD_W = 2 * OPERAND_W,
  localparam int MULT_W = 2 * HALF_W + 2
) (
  input  logic [PROD_W-1:0]         acc,
  input  logic [MULT_W-1:0]         tmp,
  input  logic                      alu_sub,
  input  karatsuba_pkg::shift_sel_t shift_sel,
  output logic [PROD_W-1:0]         alu_out
);

  import karatsuba_pkg::*;

  logic [PROD_W-1:0] tmp_ext;
  logic [PROD_W-1:0] tmp_shifted;

  assign tmp_ext = PROD_W'(tmp);

  always_comb begin
    case (shift_sel)
      SHIFT_HALF: tmp_shifted = tmp_ext << HALF_W;
      SHIFT_FULL: tmp_shifted = tmp_ext << (2 * HALF_W);
      default:    tmp_shifted = tmp_ext;
    endcase
  end

  // Carry out is dropped, arithmetic wraps at the product width
  always_comb begin
    if (alu_sub) begin
      alu_out = acc - tmp_shifted;
    end else begin
      alu_out = acc + tmp_shifted;
    end
  end

endmodule

/* rtl/karatsuba_datapath.sv */
`timescale 1ns/1ns

module karatsuba_datapath #(
  parameter int OPERAND_W = karatsuba_pkg::DEFAULT_OPERAND_W,
  localparam int HALF_W = OPERAND_W / 2,
  localparam int PROD_W = 2 * OPERAND_W,
  localparam int MULT_W = 2 * HALF_W + 2
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [OPERAND_W-1:0]      op_a,
  input  logic [OPERAND_W-1:0]      op_b,
  input  logic                      load_op,
  input  logic                      load_acc,
  input  logic                      acc_from_alu,
  input  logic                      load_tmp,
  input  logic                      alu_sub,
  input  karatsuba_pkg::mult_sel_t  mult_sel,
  input  karatsuba_pkg::shift_sel_t shift_sel,
  output logic [PROD_W-1:0]         acc
);

  logic [OPERAND_W-1:0] op_a_q;
  logic [OPERAND_W-1:0] op_b_q;
  logic [MULT_W-1:0]    tmp;
  logic [MULT_W-1:0]    mult_out;
  logic [PROD_W-1:0]    alu_out;
  logic [PROD_W-1:0]    acc_next;

  karatsuba_half_mult #(
    .OPERAND_W (OPERAND_W)
  ) u_half_mult (
    .op_a     (op_a_q),
    .op_b     (op_b_q),
    .mult_sel (mult_sel),
    .mult_out (mult_out)
  );

  karatsuba_alu #(
    .OPERAND_W (OPERAND_W)
  ) u_alu (
    .acc       (acc),
    .tmp       (tmp),
    .alu_sub   (alu_sub),
    .shift_sel (shift_sel),
    .alu_out   (alu_out)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      op_a_q <= '0;
      op_b_q <= '0;
    end else if (load_op) begin
      op_a_q <= op_a;
      op_b_q <= op_b;
    end
  end

  assign acc_next = acc_from_alu ? alu_out : PROD_W'(mult_out);

  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (load_acc) begin
      acc <= acc_next;
    end
  end

  // The ALU reads the old tmp in the same cycle that tmp reloads
  always_ff @(posedge clk) begin
    if (reset) begin
      tmp <= '0;
    end else if (load_tmp) begin
      tmp <= mult_out;
    end
  end

endmodule

/* rtl/karatsuba_result_out.sv */
`timescale 1ns/1ns

module karatsuba_result_out #(
  parameter int OPERAND_W = karatsuba_pkg::DEFAULT_OPERAND_W,
  localparam int PROD_W = 2 * OPERAND_W
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              done,
  input  logic [PROD_W-1:0] acc,
  output logic [PROD_W-1:0] product,
  output logic              product_valid
);

  // The product stays put until the next operation completes
  always_ff @(posedge clk) begin
    if (reset) begin
      product <= '0;
    end else if (done) begin
      product <= acc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      product_valid <= 1'b0;
    end else begin
      product_valid <= done;
    end
  end

endmodule

/* rtl/karatsuba_top.sv */
`timescale 1ns/1ns

module karatsuba_top #(
  parameter int OPERAND_W = karatsuba_pkg::DEFAULT_OPERAND_W
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic [OPERAND_W-1:0]   a,
  input  logic [OPERAND_W-1:0]   b,
  output logic [2*OPERAND_W-1:0] product,
  output logic                   product_valid
);

  import karatsuba_pkg::*;

  logic [OPERAND_W-1:0]   op_a;
  logic [OPERAND_W-1:0]   op_b;
  logic                   go;
  logic                   load_op;
  logic                   load_acc;
  logic                   acc_from_alu;
  logic                   load_tmp;
  logic                   alu_sub;
  logic                   done;
  mult_sel_t              mult_sel;
  shift_sel_t             shift_sel;
  logic [2*OPERAND_W-1:0] acc;

  karatsuba_operand_capture #(
    .OPERAND_W (OPERAND_W)
  ) u_capture (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .a     (a),
    .b     (b),
    .op_a  (op_a),
    .op_b  (op_b),
    .go    (go)
  );

  karatsuba_cu u_cu (
    .clk          (clk),
    .reset        (reset),
    .go           (go),
    .load_op      (load_op),
    .load_acc     (load_acc),
    .acc_from_alu (acc_from_alu),
    .load_tmp     (load_tmp),
    .alu_sub      (alu_sub),
    .done         (done),
    .mult_sel     (mult_sel),
    .shift_sel    (shift_sel)
  );

  karatsuba_datapath #(
    .OPERAND_W (OPERAND_W)
  ) u_datapath (
    .clk          (clk),
    .reset        (reset),
    .op_a         (op_a),
    .op_b         (op_b),
    .load_op      (load_op),
    .load_acc     (load_acc),
    .acc_from_alu (acc_from_alu),
    .load_tmp     (load_tmp),
    .alu_sub      (alu_sub),
    .mult_sel     (mult_sel),
    .shift_sel    (shift_sel),
    .acc          (acc)
  );

  karatsuba_result_out #(
    .OPERAND_W (OPERAND_W)
  ) u_result_out (
    .clk           (clk),
    .reset         (reset),
    .done          (done),
    .acc           (acc),
    .product       (product),
    .product_valid (product_valid)
  );

endmodule

/* tb/karatsuba_checker.sv */
`timescale 1ns/1ns

module karatsuba_checker (
  input logic clk,
  input logic reset,
  input logic done,
  input logic product_valid
);

  // Cycles since the last done, saturating at 15
  logic [3:0] since_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      since_done <= 4'd15;
    end else if (done) begin
      since_done <= 4'd0;
    end else if (since_done != 4'd15) begin
      since_done <= since_done + 4'd1;
    end
  end

  done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else $error("done stayed high for two cycles");

  valid_follows_done: assert property (@(posedge clk) disable iff (reset)
    done |=> product_valid)
    else $error("product_valid did not follow done");

  valid_low_after_reset: assert property (@(posedge clk) reset |=> !product_valid)
    else $error("product_valid high right after reset");

  // Another done needs a pass through IDLE and S0 to S6 first
  done_spacing: assert property (@(posedge clk) disable iff (reset)
    done |-> since_done >= 4'd7)
    else $error("done came back too soon after the previous one");

endmodule

bind karatsuba_top karatsuba_checker chk0 (
  .clk           (clk),
  .reset         (reset),
  .done          (done),
  .product_valid (product_valid)
);

/* tb/karatsuba_tb.sv */
`timescale 1ns/1ns

module karatsuba_tb;

  localparam int OPERAND_W = 10;
  localparam int PROD_W = 2 * OPERAND_W;
  // Edges from the sampling edge to the load of product
  localparam int LATENCY = 8;
  localparam int VALID_LIMIT = 20;
  // About 70 operations of at most 12 cycles, two idle windows and reset
  localparam int MAX_CYCLES = 2000;

  logic                 clk;
  logic                 reset;
  logic                 start;
  logic [OPERAND_W-1:0] a;
  logic [OPERAND_W-1:0] b;
  logic [PROD_W-1:0]    product;
  logic                 product_valid;

  logic [31:0] rng_state;
  int          errors = 0;
  int          checks = 0;
  int          cycle_count = 0;

  karatsuba_top #(
    .OPERAND_W (OPERAND_W)
  ) dut0 (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .a             (a),
    .b             (b),
    .product       (product),
    .product_valid (product_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] ref_product(input logic [OPERAND_W-1:0] x,
                                              input logic [OPERAND_W-1:0] y);
    return 32'(x) * 32'(y);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic start_op(input logic [OPERAND_W-1:0] a_val,
                          input logic [OPERAND_W-1:0] b_val);
    @(posedge clk);
    a <= a_val;
    b <= b_val;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  // Counts falling edges from the sampling edge until product_valid is seen
  task automatic wait_valid(output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!product_valid && cycles < VALID_LIMIT);
    if (!product_valid) begin
      $display("product_valid did not rise within %0d cycles of start", VALID_LIMIT);
      errors++;
    end
  endtask

  task automatic run_op(input logic [OPERAND_W-1:0] a_val,
                        input logic [OPERAND_W-1:0] b_val);
    int cycles;
    start_op(a_val, b_val);
    wait_valid(cycles);
    check_value("product", ref_product(a_val, b_val), 32'(product));
  endtask

  task automatic count_valids(input int n, output int valid_count);
    valid_count = 0;
    repeat (n) begin
      @(negedge clk);
      if (product_valid) begin
        valid_count++;
      end
    end
  endtask

  task automatic test_corners();
    run_op(10'd0, 10'd0);
    run_op(10'd0, 10'd1023);
    run_op(10'd1, 10'd777);
    run_op(10'd777, 10'd1);
    run_op(10'd1023, 10'd1023);
    run_op(10'h3e0, 10'h3e0);
    // Low halves only, so the middle-term subtractions wrap below zero
    run_op(10'h01f, 10'h01f);
    run_op(10'h3e0, 10'h01f);
    run_op(10'h01f, 10'h3e0);
    run_op(10'd1023, 10'd1);
  endtask

  task automatic test_random();
    logic [OPERAND_W-1:0] a_val;
    logic [OPERAND_W-1:0] b_val;
    repeat (50) begin
      rng_state = xorshift(rng_state);
      a_val = rng_state[OPERAND_W-1:0];
      rng_state = xorshift(rng_state);
      b_val = rng_state[OPERAND_W-1:0];
      run_op(a_val, b_val);
    end
  endtask

  task automatic test_latency();
    int cycles;
    start_op(10'd345, 10'd678);
    wait_valid(cycles);
    // product_valid shows at the falling edge after the eighth rising edge
    check_value("latency", 32'(LATENCY + 1), 32'(cycles));
    check_value("product", ref_product(10'd345, 10'd678), 32'(product));
    @(negedge clk);
    check_value("product_valid", 32'd0, 32'(product_valid));
  endtask

  task automatic test_start_during_op();
    int cycles;
    int valid_count;
    start_op(10'd600, 10'd901);
    @(posedge clk);
    start_op(10'd123, 10'd456);
    wait_valid(cycles);
    check_value("product", ref_product(10'd600, 10'd901), 32'(product));
    valid_count = 0;
    repeat (12) begin
      @(negedge clk);
      if (product_valid) begin
        valid_count++;
      end
      check_value("product", ref_product(10'd600, 10'd901), 32'(product));
    end
    check_value("product_valid count", 32'd0, 32'(valid_count));
  endtask

  task automatic test_reset_during_op();
    int valid_count;
    start_op(10'd999, 10'd998);
    repeat (3) @(posedge clk);
    reset <= 1'b1;
    @(posedge clk);
    reset <= 1'b0;
    count_valids(12, valid_count);
    check_value("product_valid count", 32'd0, 32'(valid_count));
    check_value("product", 32'd0, 32'(product));
    run_op(10'd321, 10'd654);
  endtask

  initial begin
    reset = 1'b1;
    start = 1'b0;
    a = '0;
    b = '0;
    rng_state = 32'h544b;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    test_corners();
    test_random();
    test_latency();
    test_start_during_op();
    test_reset_during_op();
    repeat (2) @(posedge clk);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* filelist.f */
rtl/karatsuba_pkg.sv
rtl/karatsuba_operand_capture.sv
rtl/karatsuba_cu.sv
rtl/karatsuba_half_mult.sv
rtl/karatsuba_alu.sv
rtl/karatsuba_datapath.sv
rtl/karatsuba_result_out.sv
rtl/karatsuba_top.sv
tb/karatsuba_checker.sv
tb/karatsuba_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = karatsuba_tb
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
